//--- files.f
+incdir+src
src/vcache_pkg.sv
src/vcache_req_adapter.sv
src/vcache_core.sv
src/vcache_dma_link.sv
src/vcache_tile.sv
verification/vcache_tile_asserts.sv
verification/vcache_tile_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the cache tile testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -j 0 --timescale 1ns/100ps \
  -f files.f --top-module vcache_tile_tb --Mdir "$build_dir" -o vcache_tile_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

"./$build_dir/vcache_tile_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi
if grep -qx "SIMULATION PASSED" "$log_file"; then
  exit 0
fi
echo "pass message not found in $log_file"
exit 1

//--- verification/vcache_tile_tb.sv
// cache tile testbench: seeded random traffic checked against a reference cache and memory
`timescale 1ns/100ps
`include "vcache_settings.svh"

module vcache_tile_tb;
  import vcache_pkg::*;

  localparam int num_requests   = 400;
  localparam int timeout_cycles = 2000;
  localparam int mem_words      = 1 << `VCACHE_ADDR_WIDTH;
  localparam int num_sets       = `VCACHE_SETS;

  // handshake lines that wait_level can watch
  localparam int req_ack_line  = 0;
  localparam int resp_req_line = 1;
  localparam int mem_req_line  = 2;
  localparam int mem_ack_line  = 3;

  logic        clk_i = 1'b0;
  logic        rst_i;
  cache_req_s  net_req_i;
  logic        net_req_req_i;
  logic        net_req_ack_o;
  cache_resp_s net_resp_o;
  logic        net_resp_req_o;
  logic        net_resp_ack_i;
  mem_req_s    mem_req_o;
  logic        mem_req_req_o;
  logic        mem_req_ack_i;
  mem_resp_s   mem_resp_i;
  logic        mem_resp_req_i;
  logic        mem_resp_ack_o;

  integer      seed;
  logic        all_done;
  logic        verdict_done;
  int          stalls;
  int          load_hits;
  int          conflict_misses;
  int          resp_count;

  // backing store and its reference copy
  data_word_t  mem_data [mem_words];
  data_word_t  ref_mem [mem_words];

  // reference cache state
  logic        ref_valid [num_sets];
  cache_tag_t  ref_tag [num_sets];
  data_word_t  ref_data [num_sets];

  mem_req_s    exp_mem_q [$];
  cache_resp_s exp_resp_q [$];

  vcache_tile vcache_tile_inst (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .net_req_i      (net_req_i),
    .net_req_req_i  (net_req_req_i),
    .net_req_ack_o  (net_req_ack_o),
    .net_resp_o     (net_resp_o),
    .net_resp_req_o (net_resp_req_o),
    .net_resp_ack_i (net_resp_ack_i),
    .mem_req_o      (mem_req_o),
    .mem_req_req_o  (mem_req_req_o),
    .mem_req_ack_i  (mem_req_ack_i),
    .mem_resp_i     (mem_resp_i),
    .mem_resp_req_i (mem_resp_req_i),
    .mem_resp_ack_o (mem_resp_ack_o)
  );

  always #5 clk_i = ~clk_i;

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  task automatic end_with_failure();
    verdict_done = 1'b1;
    $display("SIMULATION FAILED");
    $fatal(1, "testbench check failed");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Error: %s expected %h actual %h", name, expected, actual);
      end_with_failure();
    end
  endtask

  task automatic report_error(input string what);
    $display("Error: %s", what);
    end_with_failure();
  endtask

  function automatic logic line_value(input int line);
    case (line)
      req_ack_line:  return net_req_ack_o;
      resp_req_line: return net_resp_req_o;
      mem_req_line:  return mem_req_req_o;
      mem_ack_line:  return mem_resp_ack_o;
      default:       return 1'b0;
    endcase
  endfunction

  // poll one handshake line on falling edges until it reaches the level
  task automatic wait_level(input int line, input logic level, input string what);
    int cycles;
    cycles = 0;
    while (line_value(line) !== level) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > timeout_cycles) report_error($sformatf("timed out waiting for %s", what));
    end
  endtask

  // write-through, no write allocate, one word per line
  task automatic predict(input cache_req_s req);
    set_index_t  idx;
    cache_tag_t  tag;
    logic        hit;
    mem_req_s    mreq;
    cache_resp_s resp;
    idx       = req.addr[$bits(set_index_t)-1:0];
    tag       = req.addr[`VCACHE_ADDR_WIDTH-1:$bits(set_index_t)];
    hit       = ref_valid[idx] && (ref_tag[idx] == tag);
    mreq.we   = (req.op == e_op_store);
    mreq.addr = req.addr;
    mreq.data = req.data;
    resp.op   = req.op;
    if (req.op == e_op_store) begin
      exp_mem_q.push_back(mreq);
      ref_mem[req.addr] = req.data;
      if (hit) ref_data[idx] = req.data;
      resp.data = req.data;
    end else if (hit) begin
      load_hits++;
      resp.data = ref_data[idx];
    end else begin
      if (ref_valid[idx]) conflict_misses++;
      exp_mem_q.push_back(mreq);
      ref_valid[idx] = 1'b1;
      ref_tag[idx]   = tag;
      ref_data[idx]  = ref_mem[req.addr];
      resp.data      = ref_data[idx];
    end
    exp_resp_q.push_back(resp);
  endtask

  task automatic drive_requests();
    cache_req_s  req;
    logic [31:0] r;
    for (int n = 0; n < num_requests; n++) begin
      r = rand_word();
      if (r[0]) @(negedge clk_i);
      req.op = (r[4:3] == 2'b00) ? e_op_store : e_op_load;
      // four sets times four tags
      req.addr      = '0;
      req.addr[1:0] = r[6:5];
      req.addr[5:4] = r[8:7];
      req.data      = rand_word();
      predict(req);
      net_req_i     = req;
      net_req_req_i = 1'b1;
      @(negedge clk_i);
      if (!net_req_ack_o) begin
        stalls++;
        // ack is only held back while the request queue is full
        check_value("requests outstanding at a stall", 1,
                    32'(n - resp_count >= `VCACHE_REQ_FIFO_ELS));
      end
      wait_level(req_ack_line, 1'b1, "the request ack");
      net_req_req_i = 1'b0;
      wait_level(req_ack_line, 1'b0, "the request ack to fall");
    end
  endtask

  task automatic collect_responses();
    cache_resp_s got;
    cache_resp_s exp;
    logic [31:0] r;
    int          delay;
    for (int n = 0; n < num_requests; n++) begin
      wait_level(resp_req_line, 1'b1, "a response");
      got = net_resp_o;
      if (exp_resp_q.size() == 0) report_error("response arrived with no request outstanding");
      exp = exp_resp_q.pop_front();
      check_value("response op", 32'(exp.op), 32'(got.op));
      check_value("response data", exp.data, got.data);
      r = rand_word();
      // occasional long stalls let the request queue fill up
      delay = (r[4:3] == 2'b11) ? int'(r[9:5]) : int'(r[1:0]);
      repeat (delay) @(negedge clk_i);
      net_resp_ack_i = 1'b1;
      wait_level(resp_req_line, 1'b0, "the response req to fall");
      net_resp_ack_i = 1'b0;
      resp_count++;
    end
    all_done = 1'b1;
  endtask

  task automatic serve_memory();
    mem_req_s    got;
    mem_req_s    exp;
    logic [31:0] r;
    int          cycles;
    while (!all_done) begin
      cycles = 0;
      while (!mem_req_req_o && !all_done) begin
        @(negedge clk_i);
        cycles++;
        if (cycles > timeout_cycles) report_error("timed out waiting for a memory request");
      end
      if (mem_req_req_o) begin
        r = rand_word();
        repeat (r[2:0]) @(negedge clk_i);
        got = mem_req_o;
        if (exp_mem_q.size() == 0) report_error("memory request the cache model did not expect");
        exp = exp_mem_q.pop_front();
        check_value("memory write enable", 32'(exp.we), 32'(got.we));
        check_value("memory address", 32'(exp.addr), 32'(got.addr));
        if (got.we) begin
          check_value("memory write data", exp.data, got.data);
          mem_data[got.addr] = got.data;
        end
        mem_req_ack_i = 1'b1;
        wait_level(mem_req_line, 1'b0, "the memory req to fall");
        mem_req_ack_i = 1'b0;
        if (!got.we) begin
          repeat (r[5:3]) @(negedge clk_i);
          mem_resp_i.data = mem_data[got.addr];
          mem_resp_req_i  = 1'b1;
          wait_level(mem_ack_line, 1'b1, "the memory response ack");
          mem_resp_req_i  = 1'b0;
          wait_level(mem_ack_line, 1'b0, "the memory response ack to fall");
        end
      end
    end
  endtask

  initial begin
    seed            = 32'haab1_15aa;
    rst_i           = 1'b1;
    net_req_i       = '0;
    net_req_req_i   = 1'b0;
    net_resp_ack_i  = 1'b0;
    mem_req_ack_i   = 1'b0;
    mem_resp_i      = '0;
    mem_resp_req_i  = 1'b0;
    all_done        = 1'b0;
    verdict_done    = 1'b0;
    stalls          = 0;
    load_hits       = 0;
    conflict_misses = 0;
    resp_count      = 0;
    for (int a = 0; a < mem_words; a++) begin
      mem_data[a] = rand_word();
      ref_mem[a]  = mem_data[a];
    end
    for (int s = 0; s < num_sets; s++) begin
      ref_valid[s] = 1'b0;
    end
    repeat (4) @(negedge clk_i);
    rst_i = 1'b0;
    // the tile holds its own reset one cycle longer
    repeat (2) @(negedge clk_i);
    check_value("idle request ack", 0, 32'(net_req_ack_o));
    check_value("idle response req", 0, 32'(net_resp_req_o));
    check_value("idle memory req", 0, 32'(mem_req_req_o));
    check_value("idle memory response ack", 0, 32'(mem_resp_ack_o));
    fork
      drive_requests();
      collect_responses();
      serve_memory();
    join
    // the tile stays quiet once every request is answered
    repeat (8) @(negedge clk_i);
    check_value("response req after the last response", 0, 32'(net_resp_req_o));
    check_value("memory req after the last response", 0, 32'(mem_req_req_o));
    check_value("memory requests left over", 0, exp_mem_q.size());
    check_value("queue back-pressure seen", 1, 32'(stalls > 0));
    check_value("load hits seen", 1, 32'(load_hits > 0));
    check_value("set conflicts seen", 1, 32'(conflict_misses > 0));
    verdict_done = 1'b1;
    $display("SIMULATION PASSED");
    $finish;
  end

  final begin
    if (!verdict_done) $display("SIMULATION FAILED");
  end

endmodule

//--- verification/vcache_tile_asserts.sv
// cache tile handshake checks: four-phase ordering and payload stability on external channels
`timescale 1ns/100ps

module vcache_tile_asserts (
  input logic                    clk_i,
  input logic                    rst_i,
  input vcache_pkg::cache_req_s  net_req_i,
  input logic                    net_req_req_i,
  input logic                    net_req_ack_o,
  input vcache_pkg::cache_resp_s net_resp_o,
  input logic                    net_resp_req_o,
  input logic                    net_resp_ack_i,
  input vcache_pkg::mem_req_s    mem_req_o,
  input logic                    mem_req_req_o,
  input logic                    mem_req_ack_i,
  input vcache_pkg::mem_resp_s   mem_resp_i,
  input logic                    mem_resp_req_i,
  input logic                    mem_resp_ack_o
);

  // network request, tile receives
  req_ack_rise: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(net_req_ack_o) |-> $past(net_req_req_i)) else $error("request ack rose without req");
  req_ack_fall: assert property (@(posedge clk_i) disable iff (rst_i)
    $fell(net_req_ack_o) |-> !$past(net_req_req_i)) else $error("request ack fell before req");
  req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    net_req_req_i && $past(net_req_req_i) |-> $stable(net_req_i))
    else $error("request payload changed while req high");

  // network response, tile sends
  resp_req_rise: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(net_resp_req_o) |-> !$past(net_resp_ack_i)) else $error("response req rose during ack");
  resp_req_fall: assert property (@(posedge clk_i) disable iff (rst_i)
    $fell(net_resp_req_o) |-> $past(net_resp_ack_i)) else $error("response req fell before ack");
  resp_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    net_resp_req_o && $past(net_resp_req_o) |-> $stable(net_resp_o))
    else $error("response payload changed while req high");

  // memory request, tile sends
  mem_req_rise: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(mem_req_req_o) |-> !$past(mem_req_ack_i)) else $error("memory req rose during ack");
  mem_req_fall: assert property (@(posedge clk_i) disable iff (rst_i)
    $fell(mem_req_req_o) |-> $past(mem_req_ack_i)) else $error("memory req fell before ack");
  mem_req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    mem_req_req_o && $past(mem_req_req_o) |-> $stable(mem_req_o))
    else $error("memory request payload changed while req high");

  // memory response, tile receives
  mem_ack_rise: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(mem_resp_ack_o) |-> $past(mem_resp_req_i)) else $error("memory ack rose without req");
  mem_ack_fall: assert property (@(posedge clk_i) disable iff (rst_i)
    $fell(mem_resp_ack_o) |-> !$past(mem_resp_req_i)) else $error("memory ack fell before req");
  mem_resp_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    mem_resp_req_i && $past(mem_resp_req_i) |-> $stable(mem_resp_i))
    else $error("memory response payload changed while req high");

endmodule

bind vcache_tile vcache_tile_asserts vcache_tile_asserts_inst (
  .clk_i          (clk_i),
  .rst_i          (rst_i),
  .net_req_i      (net_req_i),
  .net_req_req_i  (net_req_req_i),
  .net_req_ack_o  (net_req_ack_o),
  .net_resp_o     (net_resp_o),
  .net_resp_req_o (net_resp_req_o),
  .net_resp_ack_i (net_resp_ack_i),
  .mem_req_o      (mem_req_o),
  .mem_req_req_o  (mem_req_req_o),
  .mem_req_ack_i  (mem_req_ack_i),
  .mem_resp_i     (mem_resp_i),
  .mem_resp_req_i (mem_resp_req_i),
  .mem_resp_ack_o (mem_resp_ack_o)
);

//--- src/vcache_tile.sv
// cache tile top: reset register plus request adapter, cache core and dma link
`timescale 1ns/100ps

module vcache_tile (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  vcache_pkg::cache_req_s  net_req_i,
  input  logic                    net_req_req_i,
  output logic                    net_req_ack_o,
  output vcache_pkg::cache_resp_s net_resp_o,
  output logic                    net_resp_req_o,
  input  logic                    net_resp_ack_i,
  output vcache_pkg::mem_req_s    mem_req_o,
  output logic                    mem_req_req_o,
  input  logic                    mem_req_ack_i,
  input  vcache_pkg::mem_resp_s   mem_resp_i,
  input  logic                    mem_resp_req_i,
  output logic                    mem_resp_ack_o
);
  import vcache_pkg::*;

  logic        rst_r;

  cache_req_s  req;
  logic        req_v;
  logic        req_ready;
  cache_resp_s resp;
  logic        resp_v;
  logic        resp_ready;
  mem_req_s    dma;
  logic        dma_v;
  logic        dma_ready;
  data_word_t  fill;
  logic        fill_v;
  logic        fill_ready;

  // all blocks see reset one cycle late
  always_ff @(posedge clk_i) begin
    rst_r <= rst_i;
  end

  vcache_req_adapter req_adapter_inst (
    .clk_i          (clk_i),
    .rst_i          (rst_r),
    .net_req_i      (net_req_i),
    .net_req_req_i  (net_req_req_i),
    .net_req_ack_o  (net_req_ack_o),
    .req_v_o        (req_v),
    .req_o          (req),
    .req_ready_i    (req_ready),
    .resp_v_i       (resp_v),
    .resp_i         (resp),
    .resp_ready_o   (resp_ready),
    .net_resp_o     (net_resp_o),
    .net_resp_req_o (net_resp_req_o),
    .net_resp_ack_i (net_resp_ack_i)
  );

  vcache_core core_inst (
    .clk_i        (clk_i),
    .rst_i        (rst_r),
    .req_v_i      (req_v),
    .req_i        (req),
    .req_ready_o  (req_ready),
    .resp_v_o     (resp_v),
    .resp_o       (resp),
    .resp_ready_i (resp_ready),
    .dma_v_o      (dma_v),
    .dma_o        (dma),
    .dma_ready_i  (dma_ready),
    .fill_v_i     (fill_v),
    .fill_i       (fill),
    .fill_ready_o (fill_ready)
  );

  vcache_dma_link dma_link_inst (
    .clk_i          (clk_i),
    .rst_i          (rst_r),
    .dma_v_i        (dma_v),
    .dma_i          (dma),
    .dma_ready_o    (dma_ready),
    .mem_req_o      (mem_req_o),
    .mem_req_req_o  (mem_req_req_o),
    .mem_req_ack_i  (mem_req_ack_i),
    .mem_resp_i     (mem_resp_i),
    .mem_resp_req_i (mem_resp_req_i),
    .mem_resp_ack_o (mem_resp_ack_o),
    .fill_v_o       (fill_v),
    .fill_o         (fill),
    .fill_ready_i   (fill_ready)
  );

endmodule

//--- src/vcache_dma_link.sv
// dma link: four-phase memory request sender and memory response receiver
`timescale 1ns/100ps

module vcache_dma_link (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   dma_v_i,
  input  vcache_pkg::mem_req_s   dma_i,
  output logic                   dma_ready_o,
  output vcache_pkg::mem_req_s   mem_req_o,
  output logic                   mem_req_req_o,
  input  logic                   mem_req_ack_i,
  input  vcache_pkg::mem_resp_s  mem_resp_i,
  input  logic                   mem_resp_req_i,
  output logic                   mem_resp_ack_o,
  output logic                   fill_v_o,
  output vcache_pkg::data_word_t fill_o,
  input  logic                   fill_ready_i
);
  import vcache_pkg::*;

  phase_state_e state_r;
  mem_req_s     req_r;
  logic         rd_pending_r;
  logic         accept;
  logic         fill_take;
  logic         resp_capture;

  assign dma_ready_o   = (state_r == e_phase_idle);
  assign accept        = dma_v_i && dma_ready_o;
  assign mem_req_req_o = (state_r == e_phase_req);
  assign mem_req_o     = req_r;

  assign fill_take     = fill_v_o && fill_ready_i;
  // one word held at a time, next response waits for the core
  assign resp_capture  = mem_resp_req_i && !mem_resp_ack_o && !fill_v_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_r      <= e_phase_idle;
      rd_pending_r <= 1'b0;
    end else begin
      if (accept && !dma_i.we) begin
        rd_pending_r <= 1'b1;
      end else if (fill_take) begin
        rd_pending_r <= 1'b0;
      end
      case (state_r)
        e_phase_idle: begin
          if (dma_v_i) state_r <= e_phase_req;
        end
        e_phase_req: begin
          if (mem_req_ack_i) state_r <= e_phase_release;
        end
        e_phase_release: begin
          // a write is done here, a read still needs its data
          if (!mem_req_ack_i) begin
            state_r <= (rd_pending_r && !fill_take) ? e_phase_wait : e_phase_idle;
          end
        end
        e_phase_wait: begin
          if (fill_take) state_r <= e_phase_idle;
        end
        default: state_r <= e_phase_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_r <= dma_i;
    end
  end

  // response receiver
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mem_resp_ack_o <= 1'b0;
      fill_v_o       <= 1'b0;
    end else begin
      if (resp_capture) begin
        mem_resp_ack_o <= 1'b1;
        fill_v_o       <= 1'b1;
      end else begin
        if (mem_resp_ack_o && !mem_resp_req_i) mem_resp_ack_o <= 1'b0;
        if (fill_take) fill_v_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (resp_capture) begin
      fill_o <= mem_resp_i.data;
    end
  end

endmodule

//--- src/vcache_core.sv
// cache core: direct-mapped write-through tag and data array with its control FSM
`timescale 1ns/100ps
`include "vcache_settings.svh"

module vcache_core (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    req_v_i,
  input  vcache_pkg::cache_req_s  req_i,
  output logic                    req_ready_o,
  output logic                    resp_v_o,
  output vcache_pkg::cache_resp_s resp_o,
  input  logic                    resp_ready_i,
  output logic                    dma_v_o,
  output vcache_pkg::mem_req_s    dma_o,
  input  logic                    dma_ready_i,
  input  logic                    fill_v_i,
  input  vcache_pkg::data_word_t  fill_i,
  output logic                    fill_ready_o
);
  import vcache_pkg::*;

  localparam int unsigned num_sets = `VCACHE_SETS;

  data_word_t           data_mem [num_sets];
  cache_tag_t           tag_mem [num_sets];
  logic [num_sets-1:0]  valid_r;

  core_state_e          state_r;
  cache_req_s           req_r;
  data_word_t           resp_data_r;

  set_index_t           idx;
  cache_tag_t           tag;
  logic                 hit;
  logic                 is_store;

  // split the held address into line index and tag
  assign idx      = req_r.addr[$bits(set_index_t)-1:0];
  assign tag      = req_r.addr[`VCACHE_ADDR_WIDTH-1 -: $bits(cache_tag_t)];
  assign hit      = valid_r[idx] && (tag_mem[idx] == tag);
  assign is_store = (req_r.op == e_op_store);

  assign req_ready_o  = (state_r == e_core_idle);
  assign dma_v_o      = (state_r == e_core_issue);
  assign fill_ready_o = (state_r == e_core_fill_wait);
  assign resp_v_o     = (state_r == e_core_respond);

  assign dma_o.we   = is_store;
  assign dma_o.addr = req_r.addr;
  assign dma_o.data = req_r.data;

  assign resp_o.op   = req_r.op;
  assign resp_o.data = resp_data_r;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_r <= e_core_idle;
      valid_r <= '0;
    end else begin
      case (state_r)
        e_core_idle: begin
          if (req_v_i) state_r <= e_core_lookup;
        end
        e_core_lookup: begin
          // only a load hit skips memory
          if (!is_store && hit) begin
            state_r <= e_core_respond;
          end else begin
            state_r <= e_core_issue;
          end
        end
        e_core_issue: begin
          if (dma_ready_i) begin
            state_r <= is_store ? e_core_respond : e_core_fill_wait;
          end
        end
        e_core_fill_wait: begin
          if (fill_v_i) begin
            valid_r[idx] <= 1'b1;
            state_r      <= e_core_respond;
          end
        end
        e_core_respond: begin
          if (resp_ready_i) state_r <= e_core_idle;
        end
        default: state_r <= e_core_idle;
      endcase
    end
  end

  // request, response data and array contents
  always_ff @(posedge clk_i) begin
    if (req_v_i && req_ready_o) begin
      req_r <= req_i;
    end
    if (state_r == e_core_lookup) begin
      if (is_store) begin
        resp_data_r <= req_r.data;
        // write-through, the line only follows when it already holds the word
        if (hit) data_mem[idx] <= req_r.data;
      end else begin
        resp_data_r <= data_mem[idx];
      end
    end
    if (fill_v_i && fill_ready_o) begin
      data_mem[idx] <= fill_i;
      tag_mem[idx]  <= tag;
      resp_data_r   <= fill_i;
    end
  end

endmodule

//--- src/vcache_req_adapter.sv
// request adapter: four-phase network receiver, request queue and response sender
`timescale 1ns/100ps
`include "vcache_settings.svh"

module vcache_req_adapter (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  vcache_pkg::cache_req_s  net_req_i,
  input  logic                    net_req_req_i,
  output logic                    net_req_ack_o,
  output logic                    req_v_o,
  output vcache_pkg::cache_req_s  req_o,
  input  logic                    req_ready_i,
  input  logic                    resp_v_i,
  input  vcache_pkg::cache_resp_s resp_i,
  output logic                    resp_ready_o,
  output vcache_pkg::cache_resp_s net_resp_o,
  output logic                    net_resp_req_o,
  input  logic                    net_resp_ack_i
);
  import vcache_pkg::*;

  localparam int unsigned fifo_depth = `VCACHE_REQ_FIFO_ELS;
  localparam int unsigned ptr_width  = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
  localparam int unsigned cnt_width  = $clog2(fifo_depth + 1);

  cache_req_s           queue_mem [fifo_depth];
  logic [ptr_width-1:0] wr_ptr_r;
  logic [ptr_width-1:0] rd_ptr_r;
  logic [cnt_width-1:0] count_r;
  logic                 full;
  logic                 enq;
  logic                 deq;

  phase_state_e         resp_state_r;
  cache_resp_s          resp_r;

  // circular wrap, depth need not be a power of two
  function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
    return (ptr == ptr_width'(fifo_depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full    = (count_r == cnt_width'(fifo_depth));
  // take a new request only between handshakes and with room left
  assign enq     = net_req_req_i && !net_req_ack_o && !full;
  assign deq     = req_v_o && req_ready_i;
  assign req_v_o = (count_r != '0);
  assign req_o   = queue_mem[rd_ptr_r];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_r      <= '0;
      rd_ptr_r      <= '0;
      count_r       <= '0;
      net_req_ack_o <= 1'b0;
    end else begin
      if (enq) begin
        wr_ptr_r      <= next_ptr(wr_ptr_r);
        net_req_ack_o <= 1'b1;
      end else if (net_req_ack_o && !net_req_req_i) begin
        net_req_ack_o <= 1'b0;
      end
      if (deq) begin
        rd_ptr_r <= next_ptr(rd_ptr_r);
      end
      case ({enq, deq})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (enq) begin
      queue_mem[wr_ptr_r] <= net_req_i;
    end
  end

  // response sender
  assign resp_ready_o   = (resp_state_r == e_phase_idle);
  assign net_resp_req_o = (resp_state_r == e_phase_req);
  assign net_resp_o     = resp_r;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      resp_state_r <= e_phase_idle;
    end else begin
      case (resp_state_r)
        e_phase_idle:    if (resp_v_i) resp_state_r <= e_phase_req;
        e_phase_req:     if (net_resp_ack_i) resp_state_r <= e_phase_release;
        e_phase_release: if (!net_resp_ack_i) resp_state_r <= e_phase_idle;
        default:         resp_state_r <= e_phase_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (resp_v_i && resp_ready_o) begin
      resp_r <= resp_i;
    end
  end

endmodule

//--- src/vcache_pkg.sv
// vcache package: width types, opcodes, state encodings and channel messages
`include "vcache_settings.svh"

package vcache_pkg;

  typedef logic [`VCACHE_ADDR_WIDTH-1:0] word_addr_t;
  typedef logic [`VCACHE_DATA_WIDTH-1:0] data_word_t;

  // low address bits pick the line, the rest are kept as tag
  typedef logic [$clog2(`VCACHE_SETS)-1:0] set_index_t;
  typedef logic [`VCACHE_ADDR_WIDTH-$clog2(`VCACHE_SETS)-1:0] cache_tag_t;

  typedef enum logic {
    e_op_load,
    e_op_store
  } cache_op_e;

  typedef enum logic [2:0] {
    e_core_idle,
    e_core_lookup,
    e_core_issue,
    e_core_fill_wait,
    e_core_respond
  } core_state_e;

  // four-phase sender states
  // wait is only used by the dma link while a read is outstanding
  typedef enum logic [1:0] {
    e_phase_idle,
    e_phase_req,
    e_phase_release,
    e_phase_wait
  } phase_state_e;

  typedef struct packed {
    cache_op_e  op;
    word_addr_t addr;
    data_word_t data;
  } cache_req_s;

  typedef struct packed {
    cache_op_e  op;
    data_word_t data;
  } cache_resp_s;

  typedef struct packed {
    logic       we;
    word_addr_t addr;
    data_word_t data;
  } mem_req_s;

  typedef struct packed {
    data_word_t data;
  } mem_resp_s;

endpackage

//--- src/vcache_settings.svh
// vcache settings: fixed widths and depths shared by the cache tile
`ifndef VCACHE_SETTINGS_SVH
`define VCACHE_SETTINGS_SVH

// word address width, in bits
`define VCACHE_ADDR_WIDTH 12

// data word width, in bits
`define VCACHE_DATA_WIDTH 32

// number of direct-mapped lines, one word each
`define VCACHE_SETS 16

// entries in the network request queue
`define VCACHE_REQ_FIFO_ELS 4

`endif
